//--- Makefile
VERILATOR ?= verilator
TOP       ?= socFabricTb
FILELIST  ?= socFabric.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= TB FAILED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/socFabricTb.sv
`timescale 1ns/1ps

module socFabricTb import socPkg::*;;

    logic                        clk, arstN, read, write, readValid;
    logic                        interruptRequest, interruptAcknowledge;
    busAddr                      address;
    busData                      writeData, readData;
    byteEnable                   bwe;
    irqIndex                     interruptVector, acknowledgeIndex;
    logic [externalIrqCount-1:0] externalIrq;

    // seed, reference models and bookkeeping
    integer    seed = 32'hda97_80e8;
    busData    ramModel [ramWords];
    busData    lfsrModel, got;
    busData    expected [$];
    byteEnable lanes;
    int        index, testErrors, testsFailed, errors;
    string     currentTest;

    socFabric dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic busAddr regionAddr(int region, int offset);
        return busAddr'((region << regionShift) | (offset << 2));
    endfunction

    // lfsr reference shifts right then folds taps if a one dropped out
    function automatic busData nextLfsr(busData state);
        busData stepped;
        stepped = state >> 1;
        if (state[0]) stepped ^= lfsrTaps;
        return stepped;
    endfunction

    task automatic checkValue(busData want, busData actual);
        assert (actual == want) else begin
            $display("Error %s: expected %h, actual %h", currentTest, want, actual);
            testErrors++;
        end
    endtask

    task automatic timedOut(string what);
        $display("%s: %s did not arrive before the timeout", currentTest, what);
        testErrors++;
    endtask

    // bus tasks start and end on a falling edge
    task automatic busWrite(busAddr addr, busData data, byteEnable be);
        address   = addr;
        writeData = data;
        bwe       = be;
        write     = 1'b1;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic busRead(busAddr addr, output busData data);
        int waited;
        address = addr;
        read    = 1'b1;
        @(negedge clk);
        read   = 1'b0;
        waited = 0;
        while (!readValid && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!readValid) timedOut("readValid");
        data = readData;
    endtask

    task automatic waitRequest();
        int waited;
        waited = 0;
        while (!interruptRequest && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        if (!interruptRequest) timedOut("interruptRequest");
    endtask

    // one cycle acknowledge pulse
    task automatic acknowledge(int slot);
        acknowledgeIndex     = irqIndex'(slot);
        interruptAcknowledge = 1'b1;
        @(negedge clk);
        interruptAcknowledge = 1'b0;
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic finishTest();
        $display("%s: %0d errors", currentTest, testErrors);
        if (testErrors != 0) testsFailed++;
        errors += testErrors;
    endtask

    initial begin
        arstN = 1'b1;
        {address, read, write, bwe, writeData} = '0;
        {externalIrq, interruptAcknowledge, acknowledgeIndex} = '0;
        testsFailed = 0;
        errors      = 0;
        // arstN falls just after time zero and stays low for 8 cycles
        #1 arstN = 1'b0;
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        // a full word write makes every lane known before the masked write
        startTest("ram byte lanes");
        for (int n = 0; n < 12; n++) begin
            index = int'($unsigned($random(seed)) % ramWords);
            ramModel[index] = busData'($random(seed));
            busWrite(regionAddr(ramRegion, index), ramModel[index], 4'hf);
            got   = busData'($random(seed));
            lanes = byteEnable'($random(seed));
            busWrite(regionAddr(ramRegion, index), got, lanes);
            for (int lane = 0; lane < 4; lane++) begin
                if (lanes[lane]) ramModel[index][lane*8 +: 8] = got[lane*8 +: 8];
            end
            busRead(regionAddr(ramRegion, index), got);
            checkValue(ramModel[index], got);
        end
        finishTest();

        // read held high every cycle over ram, random and unmapped in turn
        startTest("pipelined reads");
        lfsrModel = busData'($random(seed)) | 32'h1;
        busWrite(regionAddr(randomRegion, 0), lfsrModel, 4'hf);
        for (int n = 0; n < 9; n++) begin
            if (n % 3 == 0) begin
                address = regionAddr(ramRegion, index);
                expected.push_back(ramModel[index]);
            end else if (n % 3 == 1) begin
                address = regionAddr(randomRegion, 0);
                expected.push_back(lfsrModel);
                lfsrModel = nextLfsr(lfsrModel);
            end else begin
                // region 7 lies outside the map
                address = regionAddr(7, n);
                expected.push_back(unmappedData);
            end
            read = 1'b1;
            @(negedge clk);
            if (readValid) checkValue(expected.pop_front(), readData);
            else begin
                $display("%s: no readValid one cycle after read %0d", currentTest, n);
                testErrors++;
            end
        end
        read = 1'b0;
        expected.delete();
        finishTest();

        startTest("lfsr sequence");
        lfsrModel = busData'($random(seed)) | 32'h1;
        busWrite(regionAddr(randomRegion, 0), lfsrModel, 4'hf);
        for (int n = 0; n < 12; n++) begin
            // zero seed restarts from the default
            if (n == 8) begin
                busWrite(regionAddr(randomRegion, 0), 32'd0, 4'hf);
                lfsrModel = lfsrDefaultSeed;
            end
            busRead(regionAddr(randomRegion, 0), got);
            checkValue(lfsrModel, got);
            lfsrModel = nextLfsr(lfsrModel);
        end
        finishTest();

        // channel 1 with reload 5 and only enable bit 1 set
        startTest("timer interrupt");
        busWrite(regionAddr(timerRegion, 1), 32'd5, 4'hf);
        busWrite(regionAddr(timerRegion, 3), 32'b010, 4'hf);
        waitRequest();
        checkValue(32'd1, busData'(interruptVector));
        acknowledge(timerIrqBase + 1);
        checkValue(32'd0, busData'(interruptRequest));
        busRead(regionAddr(timerRegion, 3), got);
        checkValue(32'b010, got);
        // stop the timer and clear any pulse still on its way
        busWrite(regionAddr(timerRegion, 3), 32'd0, 4'hf);
        @(negedge clk);
        @(negedge clk);
        acknowledge(timerIrqBase + 1);
        checkValue(32'd0, busData'(interruptRequest));
        finishTest();

        // slots 9 and 4 raised together and the lower index served first
        startTest("interrupt priority");
        externalIrq[9 - externalIrqBase] = 1'b1;
        externalIrq[4 - externalIrqBase] = 1'b1;
        waitRequest();
        checkValue(32'd4, busData'(interruptVector));
        acknowledge(4);
        checkValue(32'd1, busData'(interruptRequest));
        checkValue(32'd9, busData'(interruptVector));
        acknowledge(9);
        checkValue(32'd0, busData'(interruptRequest));
        externalIrq = '0;
        finishTest();

        $display("5 tests, %0d failed, %0d errors, %0d property failures",
                 testsFailed, errors, dut.props.failures);
        if (errors == 0 && dut.props.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- bench/socFabric_properties.sv
`timescale 1ns/1ps

module socFabric_properties import socPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     read,
    input logic     readValid,
    input logic     interruptRequest,
    input irqVector triggerInterrupt
);

    // failed properties so far
    int failures = 0;

    // every accepted read answers on the next edge
    readReturns: assert property (
        @(posedge clk) disable iff (!arstN) read |=> readValid
    ) else begin
        $error("read without readValid on the next edge");
        failures++;
    end

    // no response that was never asked for
    validHasRead: assert property (
        @(posedge clk) disable iff (!arstN) readValid |-> $past(read)
    ) else begin
        $error("readValid without a read one cycle earlier");
        failures++;
    end

    // outputs quiet while reset is held
    quietInReset: assert property (
        @(posedge clk) !arstN |-> !readValid && !interruptRequest
    ) else begin
        $error("readValid or interruptRequest high during reset");
        failures++;
    end

    // request only rises one edge after a sampled trigger
    requestHasTrigger: assert property (
        @(posedge clk) disable iff (!arstN)
            $rose(interruptRequest) |-> $past(triggerInterrupt) != '0
    ) else begin
        $error("interruptRequest rose without a trigger");
        failures++;
    end

endmodule

bind socFabric socFabric_properties props (
    .clk, .arstN, .read, .readValid, .interruptRequest, .triggerInterrupt
);

//--- hdl/busInterconnect.sv
`timescale 1ns/1ps

module busInterconnect import socPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  busAddr    address,
    input  logic      read,
    input  logic      write,
    input  byteEnable bwe,
    input  busData    writeData,
    output logic      readValid,
    output busData    readData,
    slaveBus.fabric   ramBus,
    slaveBus.fabric   timerBus,
    slaveBus.fabric   randomBus
);

    logic [31-regionShift:0] region;
    logic hitRam, hitTimer, hitRandom, hitNone;

    // one-hot record of the region a read targeted: ram, timer, random, none
    logic [3:0] readTarget;

    // region decode from the upper address bits
    assign region    = address[31:regionShift];
    assign hitRam    = int'(region) == ramRegion;
    assign hitTimer  = int'(region) == timerRegion;
    assign hitRandom = int'(region) == randomRegion;
    assign hitNone   = !(hitRam || hitTimer || hitRandom);

    // strobes go only to the selected slave
    assign ramBus.read     = read && hitRam;
    assign ramBus.write    = write && hitRam;
    assign timerBus.read   = read && hitTimer;
    assign timerBus.write  = write && hitTimer;
    assign randomBus.read  = read && hitRandom;
    assign randomBus.write = write && hitRandom;

    // word offset and write payload shared by all slaves
    assign ramBus.address    = address[11:2];
    assign timerBus.address  = address[11:2];
    assign randomBus.address = address[11:2];
    assign ramBus.writeData    = writeData;
    assign timerBus.writeData  = writeData;
    assign randomBus.writeData = writeData;
    assign ramBus.bwe    = bwe;
    assign timerBus.bwe  = bwe;
    assign randomBus.bwe = bwe;

    // remember the target for the returning read
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readTarget <= '0;
        end else begin
            readTarget <= read ? {hitNone, hitRandom, hitTimer, hitRam} : 4'b0000;
        end
    end

    // slave valids masked by the registered target
    // unmapped read answers by itself
    assign readValid = (readTarget[0] && ramBus.readValid)
                    || (readTarget[1] && timerBus.readValid)
                    || (readTarget[2] && randomBus.readValid)
                    || readTarget[3];

    // return path select
    always_comb begin
        readData = unmappedData;
        if (readTarget[0]) readData = ramBus.readData;
        else if (readTarget[1]) readData = timerBus.readData;
        else if (readTarget[2]) readData = randomBus.readData;
    end

endmodule

//--- hdl/interruptController.sv
`timescale 1ns/1ps

module interruptController import socPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  irqVector triggerInterrupt,
    input  logic     interruptAcknowledge,
    input  irqIndex  acknowledgeIndex,
    output logic     interruptRequest,
    output irqIndex  interruptVector
);

    irqVector triggerLast;
    irqVector risingEdge;
    irqVector ackMask;
    irqVector pending;

    // rising edge against the previous sample
    assign risingEdge = triggerInterrupt & ~triggerLast;

    // one-hot clear for the acknowledged slot
    assign ackMask = interruptAcknowledge ? irqVector'(1) << acknowledgeIndex : '0;

    // clear first, new edge on the same slot wins
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            triggerLast <= '0;
            pending     <= '0;
        end else begin
            triggerLast <= triggerInterrupt;
            pending     <= (pending & ~ackMask) | risingEdge;
        end
    end

    assign interruptRequest = |pending;

    // lowest pending index has priority
    always_comb begin
        interruptVector = '0;
        for (int i = $bits(irqVector) - 1; i >= 0; i--) begin
            if (pending[i]) interruptVector = irqIndex'(i);
        end
    end

endmodule

//--- hdl/ram.sv
`timescale 1ns/1ps

module ram import socPkg::*; (
    input  logic   clk,
    slaveBus.slave bus
);

    busData mem [ramWords];

    // byte lane writes at the accepting edge
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.bwe[lane]) begin
                    mem[bus.address][lane*8 +: 8] <= bus.writeData[lane*8 +: 8];
                end
            end
        end
    end

    // registered read, data ready one cycle later
    always_ff @(posedge clk) begin
        if (bus.read) begin
            bus.readData <= mem[bus.address];
        end
    end

    // valid follows read by one cycle
    // interconnect masks it until its target register is set
    always_ff @(posedge clk) begin
        bus.readValid <= bus.read;
    end

endmodule

//--- hdl/randomGen.sv
`timescale 1ns/1ps

module randomGen import socPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    slaveBus.slave bus
);

    busData state;
    busData nextState;

    // galois step, shift right and fold taps when a one drops out
    assign nextState = state[0] ? ((state >> 1) ^ lfsrTaps) : (state >> 1);

    // write reseeds, zero seed would lock up so use the default
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state         <= lfsrDefaultSeed;
            bus.readValid <= 1'b0;
        end else begin
            bus.readValid <= bus.read;
            if (bus.write) state <= (bus.writeData == '0) ? lfsrDefaultSeed : bus.writeData;
            else if (bus.read) state <= nextState;
        end
    end

    // current value returned, advance happens on the same edge
    always_ff @(posedge clk) begin
        if (bus.read) bus.readData <= state;
    end

endmodule

//--- hdl/reloadTimer.sv
`timescale 1ns/1ps

module reloadTimer import socPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    slaveBus.slave                 bus,
    output logic [timerCount-1:0]  timerIrq
);

    busData                reload [timerCount];
    busData                count  [timerCount];
    logic [timerCount-1:0] enable;
    logic                  enableWrite;
    busData                readWord;

    assign enableWrite = bus.write && (bus.address == 3);

    // reload registers at offsets 0 to 2
    always_ff @(posedge clk) begin
        if (bus.write && bus.address < 3) begin
            reload[bus.address[1:0]] <= bus.writeData;
        end
    end

    // counters, enables and irq pulses
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enable   <= '0;
            timerIrq <= '0;
            for (int i = 0; i < timerCount; i++) begin
                count[i] <= '0;
            end
        end else begin
            if (enableWrite) begin
                enable <= bus.writeData[timerCount-1:0];
            end
            for (int i = 0; i < timerCount; i++) begin
                // one cycle pulse when an enabled counter sits at zero
                timerIrq[i] <= enable[i] && (count[i] == '0);
                // fresh enable starts from the reload value
                if (enableWrite && bus.writeData[i] && !enable[i]) begin
                    count[i] <= reload[i];
                end else if (enable[i]) begin
                    count[i] <= (count[i] == '0) ? reload[i] : count[i] - 1'b1;
                end
            end
        end
    end

    // register map decode, 4 to 6 share low bits with 0 to 2
    always_comb begin
        readWord = '0;
        if (bus.address < 3) readWord = reload[bus.address[1:0]];
        else if (bus.address == 3) readWord = busData'(enable);
        else if (bus.address < 7) readWord = count[bus.address[1:0]];
    end

    always_ff @(posedge clk) begin
        if (bus.read) bus.readData <= readWord;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) bus.readValid <= 1'b0;
        else bus.readValid <= bus.read;
    end

endmodule

//--- hdl/slaveBus.sv
`timescale 1ns/1ps

interface slaveBus import socPkg::*;;

    // request, driven by the fabric
    logic      read;
    logic      write;
    slaveAddr  address;
    busData    writeData;
    byteEnable bwe;

    // response, readValid one cycle after read
    logic      readValid;
    busData    readData;

    modport fabric (
        output read, write, address, writeData, bwe,
        input  readValid, readData
    );

    modport slave (
        input  read, write, address, writeData, bwe,
        output readValid, readData
    );

endinterface

//--- hdl/socFabric.sv
`timescale 1ns/1ps

module socFabric import socPkg::*; (
    input  logic                        clk,
    input  logic                        arstN,

    // processor memory bus
    input  busAddr                      address,
    input  logic                        read,
    input  logic                        write,
    input  byteEnable                   bwe,
    input  busData                      writeData,
    output logic                        readValid,
    output busData                      readData,

    // interrupt lines
    input  logic [externalIrqCount-1:0] externalIrq,
    output logic                        interruptRequest,
    output irqIndex                     interruptVector,
    input  logic                        interruptAcknowledge,
    input  irqIndex                     acknowledgeIndex
);

    logic [timerCount-1:0] timerIrq;
    irqVector              triggerInterrupt;

    slaveBus ramBus ();
    slaveBus timerBus ();
    slaveBus randomBus ();

    // slot map, timers low, external lines above
    always_comb begin
        triggerInterrupt = '0;
        triggerInterrupt[timerIrqBase +: timerCount]        = timerIrq;
        triggerInterrupt[externalIrqBase +: externalIrqCount] = externalIrq;
    end

    busInterconnect busInterconnect (
        .clk, .arstN, .address, .read, .write, .bwe, .writeData,
        .readValid, .readData, .ramBus, .timerBus, .randomBus
    );

    ram ram (.clk, .bus(ramBus));

    reloadTimer reloadTimer (.clk, .arstN, .bus(timerBus), .timerIrq);

    randomGen randomGen (.clk, .arstN, .bus(randomBus));

    interruptController interruptController (
        .clk, .arstN, .triggerInterrupt, .interruptAcknowledge,
        .acknowledgeIndex, .interruptRequest, .interruptVector
    );

endmodule

//--- hdl/socPkg.sv
package socPkg;

    // master bus types
    typedef logic [31:0] busAddr;
    typedef logic [31:0] busData;
    typedef logic [3:0]  byteEnable;

    // word offset inside one slave region
    typedef logic [9:0]  slaveAddr;

    // interrupt types
    typedef logic [15:0] irqVector;
    typedef logic [3:0]  irqIndex;

    // address map, region number in bits 31 to 16
    localparam int regionShift  = 16;
    localparam int ramRegion    = 0;
    localparam int timerRegion  = 1;
    localparam int randomRegion = 2;

    // slave sizes
    localparam int ramWords   = 1024;
    localparam int timerCount = 3;

    // interrupt slot map
    localparam int timerIrqBase     = 0;
    localparam int externalIrqBase  = 3;
    localparam int externalIrqCount = 13;

    // galois lfsr feedback and restart value
    localparam busData lfsrTaps        = 32'h8020_0003;
    localparam busData lfsrDefaultSeed = 32'h0000_0001;

    // returned for reads outside every region
    localparam busData unmappedData = 32'h0000_0000;

endpackage

//--- socFabric.f
hdl/socPkg.sv
hdl/slaveBus.sv
hdl/busInterconnect.sv
hdl/ram.sv
hdl/reloadTimer.sv
hdl/randomGen.sv
hdl/interruptController.sv
hdl/socFabric.sv
bench/socFabric_properties.sv
bench/socFabricTb.sv
